// ==== hdl/attn_defs.svh ====
// Attention value stage dimensions shared by the package and the RTL
`ifndef ATTN_DEFS_SVH
`define ATTN_DEFS_SVH

// Number of elements carried by one value vector
`define VEC_LANES 4

// Width of one signed value vector element
`define ELEM_W 8

// Width of one signed attention weight
`define WEIGHT_W 8

// Width of one signed accumulator lane
// Sixteen products of two 8-bit signed values need at most 20 bits
// and 24 bits leaves plenty of headroom
`define ACC_W 24

// Longest group the processing element sums over
// This is also the FIFO depth and must stay a power of two
`define MAX_SEQ_LENGTH 16

`endif

// ==== hdl/attn_pkg.sv ====
// Data types for the attention value stage covering vectors, weights and accumulators
`default_nettype none
`include "attn_defs.svh"

package attn_pkg;

    // One signed element of a value vector
    typedef logic signed [`ELEM_W-1:0] elem_t;

    // Value vector as a packed array of signed elements with lane 0 in the low bits
    typedef elem_t [`VEC_LANES-1:0] v_vector_t;

    // One signed attention weight that is applied to every lane of a vector
    typedef logic signed [`WEIGHT_W-1:0] weight_t;

    // One signed accumulator lane
    typedef logic signed [`ACC_W-1:0] acc_t;

    // Weighted sum result with one accumulator per lane
    typedef acc_t [`VEC_LANES-1:0] acc_vector_t;

    // Group length from 1 to MAX_SEQ_LENGTH
    // One extra bit so the maximum itself fits
    typedef logic [$clog2(`MAX_SEQ_LENGTH):0] seq_len_t;

endpackage

`default_nettype wire

// ==== hdl/vector_fifo.sv ====
// First-word-fall-through FIFO for a generic payload with full and empty flags
`timescale 1ns/1ps
`default_nettype none
`include "attn_defs.svh"

module vector_fifo #(
    // Item stored per entry which is a value vector or a single weight
    parameter type payload_t = attn_pkg::v_vector_t,
    // Depth of the FIFO which must be a power of two
    parameter int NUM_ENTRIES = `MAX_SEQ_LENGTH
) (
    input  wire      clk,
    input  wire      rst,

    // Producer side takes a write only while sram_ready is high
    input  wire      write_enable,
    output logic     sram_ready,
    input  payload_t write_data,

    // Consumer side sees the oldest entry on read_data whenever read_data_valid is high
    input  wire      read_enable,
    output logic     read_data_valid,
    output payload_t read_data
);

    // Index width into the storage array
    localparam int IDX_W = $clog2(NUM_ENTRIES);

    // The full test relies on the pointers wrapping exactly at the depth
    if ((1 << IDX_W) != NUM_ENTRIES) begin : g_depth_check
        $error("vector_fifo depth %0d is not a power of two", NUM_ENTRIES);
    end

    // Storage for the queued items
    payload_t mem [NUM_ENTRIES];

    // Head and tail carry one extra wrap bit above the index
    logic [IDX_W:0] head;
    logic [IDX_W:0] tail;

    logic full;
    logic empty;
    logic do_write;
    logic do_read;

    // Equal pointers mean nothing is stored
    assign empty = (head == tail);

    // Same index on opposite laps means every slot is occupied
    assign full = (head[IDX_W] != tail[IDX_W]) &&
                  (head[IDX_W-1:0] == tail[IDX_W-1:0]);

    // Status levels seen by the two sides
    assign sram_ready      = !full;
    assign read_data_valid = !empty;

    // Transfers happen only when the flags allow them
    // A write while full is dropped, a pop while empty is ignored
    assign do_write = write_enable && !full;
    assign do_read  = read_enable && !empty;

    // The head entry is visible without a read cycle
    assign read_data = mem[head[IDX_W-1:0]];

    // Pointer update
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (do_write) begin
                tail <= tail + 1'b1;
            end
            if (do_read) begin
                head <= head + 1'b1;
            end
        end
    end

    // Storage write at the tail slot
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[tail[IDX_W-1:0]] <= write_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/weighted_sum_pe.sv ====
// Weighted-sum processing element that accumulates weight times value per lane
`timescale 1ns/1ps
`default_nettype none
`include "attn_defs.svh"

module weighted_sum_pe (
    input  wire                   clk,
    input  wire                   rst,

    // Number of pairs in a group, sampled on the first pop of each group
    input  attn_pkg::seq_len_t    seq_len,

    // Head of the value vector FIFO
    input  wire                   v_valid,
    input  attn_pkg::v_vector_t   v_data,

    // Head of the weight FIFO
    input  wire                   w_valid,
    input  attn_pkg::weight_t     w_data,

    // Pop strobe shared by both FIFOs
    output logic                  pop,

    // One-cycle result strobe while the vector holds until the next result
    output logic                  result_valid,
    output attn_pkg::acc_vector_t result_vector
);

    // Full width of one signed product
    localparam int PROD_W = `ELEM_W + `WEIGHT_W;

    // Position inside the current group where zero means a new group starts
    attn_pkg::seq_len_t pos;

    // Group length latched on the first pop
    attn_pkg::seq_len_t len_q;

    // Length in force for the current pop and the position after it
    attn_pkg::seq_len_t eff_len;
    attn_pkg::seq_len_t next_pos;

    logic first_pair;
    logic last_pair;

    // Per lane products and their sign extended form
    logic signed [PROD_W-1:0] lane_prod [`VEC_LANES];
    attn_pkg::acc_vector_t    prod_ext;

    // Running accumulator and its value after the current pop
    attn_pkg::acc_vector_t    acc;
    attn_pkg::acc_vector_t    acc_next;

    // A pair is consumed whenever both FIFOs present data
    assign pop = v_valid && w_valid;

    // Group bookkeeping
    assign first_pair = (pos == '0);

    // On the first pair the latched length is not yet loaded, so take it live
    assign eff_len  = first_pair ? seq_len : len_q;
    assign next_pos = pos + 1'b1;

    // The pair that brings the position up to the length closes the group
    assign last_pair = (next_pos == eff_len);

    // Multiply every lane by the shared weight
    always_comb begin
        for (int i = 0; i < `VEC_LANES; i++) begin
            // Both operands signed, so the 16-bit product keeps its sign
            lane_prod[i] = $signed(v_data[i]) * $signed(w_data);
            // Widen to the accumulator lane with sign extension
            prod_ext[i]  = attn_pkg::acc_t'(lane_prod[i]);
        end
    end

    // Load the products on a group's first pair, otherwise add them
    always_comb begin
        for (int i = 0; i < `VEC_LANES; i++) begin
            if (first_pair) begin
                acc_next[i] = prod_ext[i];
            end else begin
                acc_next[i] = acc[i] + prod_ext[i];
            end
        end
    end

    // Group control and result strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            pos           <= '0;
            len_q         <= '0;
            result_valid  <= 1'b0;
            result_vector <= '0;
        end else begin
            // Strobe is a single cycle unless a new result lands right behind it
            result_valid <= 1'b0;
            if (pop) begin
                if (first_pair) begin
                    len_q <= seq_len;
                end
                if (last_pair) begin
                    // Finished sum goes out and the next pop starts a new group
                    result_vector <= acc_next;
                    result_valid  <= 1'b1;
                    pos           <= '0;
                end else begin
                    pos <= next_pos;
                end
            end
        end
    end

    // Accumulator lanes
    // Each lane takes the loaded or summed value on every pop
    always_ff @(posedge clk) begin
        if (pop) begin
            acc <= acc_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/attn_value_top.sv ====
// Attention value stage top joining the vector FIFO, weight FIFO and processing element
`timescale 1ns/1ps
`default_nettype none

module attn_value_top (
    input  wire                   clk,
    input  wire                   rst,

    // Value vector stream from the memory controller
    input  wire                   v_write_enable,
    input  attn_pkg::v_vector_t   v_write_data,
    output logic                  v_ready,

    // Attention weight stream from the memory controller
    input  wire                   w_write_enable,
    input  attn_pkg::weight_t     w_write_data,
    output logic                  w_ready,

    // Group length that changes only between groups
    input  attn_pkg::seq_len_t    seq_len,

    // Weighted sum result
    output logic                  result_valid,
    output attn_pkg::acc_vector_t result_vector
);

    // Head of the vector FIFO
    logic                v_read_valid;
    attn_pkg::v_vector_t v_read_data;

    // Head of the weight FIFO
    logic                w_read_valid;
    attn_pkg::weight_t   w_read_data;

    // A single pop strobe makes vectors and weights leave their FIFOs in lockstep
    logic                pop;

    // Value vectors wait here until their weights arrive
    vector_fifo #(
        .payload_t (attn_pkg::v_vector_t)
    ) v_fifo (
        .clk             (clk),
        .rst             (rst),
        .write_enable    (v_write_enable),
        .sram_ready      (v_ready),
        .write_data      (v_write_data),
        .read_enable     (pop),
        .read_data_valid (v_read_valid),
        .read_data       (v_read_data)
    );

    // Weights wait here until their vectors arrive
    vector_fifo #(
        .payload_t (attn_pkg::weight_t)
    ) w_fifo (
        .clk             (clk),
        .rst             (rst),
        .write_enable    (w_write_enable),
        .sram_ready      (w_ready),
        .write_data      (w_write_data),
        .read_enable     (pop),
        .read_data_valid (w_read_valid),
        .read_data       (w_read_data)
    );

    // Multiply-accumulate over each group of seq_len pairs
    weighted_sum_pe pe (
        .clk           (clk),
        .rst           (rst),
        .seq_len       (seq_len),
        .v_valid       (v_read_valid),
        .v_data        (v_read_data),
        .w_valid       (w_read_valid),
        .w_data        (w_read_data),
        .pop           (pop),
        .result_valid  (result_valid),
        .result_vector (result_vector)
    );

endmodule

`default_nettype wire

// ==== tests/attn_value_chk.sv ====
// Assertion checker for FIFO flags, pop legality and result strobe spacing
`timescale 1ns/1ps
`default_nettype none

module attn_value_chk #(
    // Set on FIFO instances for the flag checks, cleared on the top for the strobe check
    parameter bit CHECK_FIFO = 1'b1
) (
    input wire                     clk,
    input wire                     rst,
    // Producer side level that is high while a write can be taken
    input wire                     level_ready,
    // Consumer side level that is high while data is waiting
    input wire                     level_valid,
    // Pop request toward the consumer side
    input wire                     pop_req,
    // Result strobe of the top level
    input wire                     strobe,
    // Group length on the input while the strobe is high
    input wire attn_pkg::seq_len_t group_len
);

    // Number of assertion failures in this instance
    int fail_count = 0;

    if (CHECK_FIFO) begin : g_fifo
        // Coming out of reset nothing is stored and writes are welcome
        reset_state: assert property (@(posedge clk)
            $fell(rst) |-> (!level_valid && level_ready))
            else begin
                fail_count++;
                $error("FIFO is not empty and ready in the first cycle after reset");
            end

        // Popping an empty FIFO would slip vectors against weights
        pop_when_empty: assert property (@(posedge clk) disable iff (rst)
            pop_req |-> level_valid)
            else begin
                fail_count++;
                $error("Pop requested while the FIFO is empty");
            end
    end else begin : g_result
        // Only a one-pair group can close in the cycle right after another result
        strobe_spacing: assert property (@(posedge clk) disable iff (rst)
            (strobe && group_len > 1) |=> !strobe)
            else begin
                fail_count++;
                $error("Result strobe high in two cycles in a row with a group length above one");
            end
    end

endmodule

`default_nettype wire

// ==== tests/attn_value_tb.sv ====
// Testbench for the attention value stage with a reference weighted sum model
`timescale 1ns/1ps
`default_nettype none
`include "attn_defs.svh"

module attn_value_tb;

    // Longest run is well under half of this
    localparam int TIMEOUT_CYCLES = 4000;

    // Extreme operand values for the sign extension tests
    localparam attn_pkg::elem_t   ELEM_MIN = {1'b1, {(`ELEM_W-1){1'b0}}};
    localparam attn_pkg::elem_t   ELEM_MAX = {1'b0, {(`ELEM_W-1){1'b1}}};
    localparam attn_pkg::weight_t W_MIN    = {1'b1, {(`WEIGHT_W-1){1'b0}}};
    localparam attn_pkg::weight_t W_MAX    = {1'b0, {(`WEIGHT_W-1){1'b1}}};

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  v_write_enable;
    attn_pkg::v_vector_t   v_write_data;
    logic                  v_ready;
    logic                  w_write_enable;
    attn_pkg::weight_t     w_write_data;
    logic                  w_ready;
    attn_pkg::seq_len_t    seq_len;
    logic                  result_valid;
    attn_pkg::acc_vector_t result_vector;

    // Accepted writes in order, and expected results per group
    attn_pkg::v_vector_t   v_q[$];
    attn_pkg::weight_t     w_q[$];
    attn_pkg::acc_vector_t exp_q[$];
    attn_pkg::acc_vector_t exp_vec;

    int   seed = 48;
    int   errors = 0;
    int   cycles = 0;
    int   groups_sent = 0;
    int   results_seen = 0;
    int   pairs_sent = 0;
    int   prev_start = -1;
    int   pops_done = 0;
    logic pop_pending = 1'b0;
    // Data source is 0 for random, 1 for all most negative and 2 for mixed extremes
    int   pattern = 0;

    always #50 clk = ~clk;

    attn_value_top uut (
        .clk            (clk),
        .rst            (rst),
        .v_write_enable (v_write_enable),
        .v_write_data   (v_write_data),
        .v_ready        (v_ready),
        .w_write_enable (w_write_enable),
        .w_write_data   (w_write_data),
        .w_ready        (w_ready),
        .seq_len        (seq_len),
        .result_valid   (result_valid),
        .result_vector  (result_vector)
    );

    // Both FIFOs get the flag checks, the top gets the strobe spacing check
    bind vector_fifo attn_value_chk #(.CHECK_FIFO (1'b1)) fifo_chk (
        .clk (clk), .rst (rst), .level_ready (sram_ready), .level_valid (read_data_valid),
        .pop_req (read_enable), .strobe (1'b0), .group_len ('0)
    );
    bind attn_value_top attn_value_chk #(.CHECK_FIFO (1'b0)) top_chk (
        .clk (clk), .rst (rst), .level_ready (1'b1), .level_valid (1'b0),
        .pop_req (1'b0), .strobe (result_valid), .group_len (seq_len)
    );

    function automatic int assertion_failures();
        return uut.v_fifo.fifo_chk.fail_count + uut.w_fifo.fifo_chk.fail_count +
               uut.top_chk.fail_count;
    endfunction

    function automatic attn_pkg::v_vector_t make_vector(input int idx);
        attn_pkg::v_vector_t v;
        for (int i = 0; i < `VEC_LANES; i++) begin
            case (pattern)
                1:       v[i] = ELEM_MIN;
                2:       v[i] = ((idx + i) % 2 == 1) ? ELEM_MAX : ELEM_MIN;
                default: v[i] = attn_pkg::elem_t'($random(seed));
            endcase
        end
        return v;
    endfunction

    function automatic attn_pkg::weight_t make_weight(input int idx);
        case (pattern)
            1:       return W_MIN;
            2:       return (idx % 3 == 0) ? W_MAX : W_MIN;
            default: return attn_pkg::weight_t'($random(seed));
        endcase
    endfunction

    // Expected sum of one group, consuming its pairs from the queues
    function automatic attn_pkg::acc_vector_t ref_sum(input int len);
        attn_pkg::acc_vector_t sum;
        attn_pkg::v_vector_t   v;
        attn_pkg::weight_t     w;
        int                    lane_total [`VEC_LANES];
        for (int i = 0; i < `VEC_LANES; i++) begin
            lane_total[i] = 0;
        end
        repeat (len) begin
            v = v_q.pop_front();
            w = w_q.pop_front();
            for (int i = 0; i < `VEC_LANES; i++) begin
                lane_total[i] += int'(v[i]) * int'(w);
            end
        end
        for (int i = 0; i < `VEC_LANES; i++) begin
            sum[i] = attn_pkg::acc_t'(lane_total[i]);
        end
        return sum;
    endfunction

    // Step to the next falling edge and account for the pop seen one edge earlier
    task automatic tick();
        @(negedge clk);
        if (pop_pending) begin
            pops_done++;
        end
        pop_pending = uut.pop;
    endtask

    task automatic expect_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic wait_results();
        while (results_seen < groups_sent) begin
            tick();
        end
    endtask

    // Mode 0 writes pairs in lockstep, mode 1 skews vectors ahead with idle cycles,
    // mode 2 fills the vector FIFO first and tries one write too many
    task automatic send_group(input int len, input int mode);
        int   nv;
        int   nw;
        int   lag;
        logic dropped;
        nv      = 0;
        nw      = 0;
        dropped = 1'b0;
        lag     = 4 + ($random(seed) & 7);
        // seq_len may only move once the previous group has latched its own
        while (pops_done <= prev_start) begin
            tick();
        end
        seq_len    = attn_pkg::seq_len_t'(len);
        prev_start = pairs_sent;
        pairs_sent += len;
        while (nv < len || nw < len) begin
            v_write_enable = 1'b0;
            w_write_enable = 1'b0;
            if (mode == 2 && nv == len && !dropped) begin
                expect_bit("v_ready", v_ready, 1'b0);
                // This vector hits a full FIFO and must vanish
                v_write_data   = make_vector(nv);
                v_write_enable = 1'b1;
                dropped        = 1'b1;
            end else if (nv < len && v_ready && (mode != 1 || ($random(seed) & 3) != 0)) begin
                v_write_data   = make_vector(nv);
                v_write_enable = 1'b1;
                v_q.push_back(v_write_data);
                nv++;
            end
            if (nw < len && w_ready && (mode == 0 || (mode == 2 && dropped) ||
                (mode == 1 && (nv - nw > lag || nv == len) && ($random(seed) & 3) != 0))) begin
                w_write_data   = make_weight(nw);
                w_write_enable = 1'b1;
                w_q.push_back(w_write_data);
                nw++;
            end
            tick();
        end
        v_write_enable = 1'b0;
        w_write_enable = 1'b0;
        exp_q.push_back(ref_sum(len));
        groups_sent++;
        if (mode == 0) begin
            // Empty FIFOs before the group, so the strobe is up two cycles after the last write
            tick();
            if (result_valid !== 1'b1) begin
                errors++;
                $display("Result of a %0d-pair group missing two cycles after its last write",
                         len);
            end
        end
    endtask

    // Compare every result strobe against the oldest expected group
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result strobe arrived with no group outstanding");
            end else begin
                exp_vec = exp_q.pop_front();
                for (int i = 0; i < `VEC_LANES; i++) begin
                    if (result_vector[i] !== exp_vec[i]) begin
                        errors++;
                        $display("** Error: result_vector lane %0d expected %h got %h",
                                 i, exp_vec[i], result_vector[i]);
                    end
                end
            end
            results_seen++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d results missing",
                     cycles, groups_sent - results_seen, groups_sent);
            $display("Errors: %0d check, %0d assertion", errors, assertion_failures());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rst            = 1'b1;
        v_write_enable = 1'b0;
        v_write_data   = '0;
        w_write_enable = 1'b0;
        w_write_data   = '0;
        seq_len        = attn_pkg::seq_len_t'(1);
        repeat (10) tick();
        rst = 1'b0;
        tick();

        expect_bit("v_ready", v_ready, 1'b1);
        expect_bit("w_ready", w_ready, 1'b1);
        expect_bit("result_valid", result_valid, 1'b0);
        if (result_vector !== '0) begin
            errors++;
            $display("** Error: result_vector expected 0 got %h", result_vector);
        end

        // Every length once with pairs written together
        for (int len = 1; len <= `MAX_SEQ_LENGTH; len++) begin
            send_group(len, 0);
        end

        // Worst case magnitude, then a mix of both extremes
        pattern = 1;
        send_group(`MAX_SEQ_LENGTH, 0);
        pattern = 2;
        send_group(`MAX_SEQ_LENGTH, 0);
        pattern = 0;

        // Fill the vector FIFO, drop one write, then release it with weights
        send_group(`MAX_SEQ_LENGTH, 2);
        wait_results();
        expect_bit("v_ready", v_ready, 1'b1);

        // Skewed streams and back-to-back groups of random length
        for (int g = 0; g < 12; g++) begin
            send_group(1 + ($random(seed) & 15), 1);
        end
        wait_results();
        repeat (5) tick();
        if (results_seen != groups_sent) begin
            errors++;
            $display("Saw %0d results for %0d groups", results_seen, groups_sent);
        end

        $display("Errors: %0d check, %0d assertion; groups %0d, results %0d",
                 errors, assertion_failures(), groups_sent, results_seen);
        if (errors == 0 && assertion_failures() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/attn_pkg.sv
hdl/vector_fifo.sv
hdl/weighted_sum_pe.sv
hdl/attn_value_top.sv
tests/attn_value_chk.sv
tests/attn_value_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the attention value stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module attn_value_tb -f vlog.f \
    && ./obj_dir/Vattn_value_tb +verilator+error+limit+100 \
        | tee /dev/stderr \
        | grep -q "Simulation finished: PASS" \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
